/* bk_defines.svh */
// Sizes are fixed for 512-byte SD sectors of 16-bit words and an 8-bit sector index
`ifndef BK_DEFINES_SVH
`define BK_DEFINES_SVH

// ==================================================
// Sector and word geometry
// ==================================================
`define BK_WORDS        256     // Words per SD sector and buffer depth
`define BK_WORD_W       16      // Width of one buffer or memory word
`define BK_LOAD_SECTORS 256     // A load always reads the largest possible save

// ==================================================
// Save size masks, in units of sectors minus one
// ==================================================
// EEPROM tops out at 8 KiB, 16 sectors
`define BK_EEPROM_MASK  8'h0F
// SRAM is 32 KiB, 64 sectors
`define BK_SRAM_MASK    8'h3F
// Flash is 64 KiB, the 1M part doubles it through the top bit
`define BK_FLASH_MASK   8'h7F

`endif

/* bk_pkg.sv */
// Widths follow bk_defines.svh and the memory address is always {sector, word}
`include "bk_defines.svh"

package bk_pkg;

	// ==================================================
	// Plain vectors
	// ==================================================
	typedef logic [`BK_WORD_W-1:0]               buf_word_t;  // One 16-bit data word
	typedef logic [$clog2(`BK_WORDS)-1:0]        word_idx_t;  // Word within a sector
	typedef logic [$clog2(`BK_LOAD_SECTORS)-1:0] sector_t;    // Sector index, also the save size
	typedef logic [$bits(sector_t)+$bits(word_idx_t)-1:0] mem_addr_t;  // {sector, word}

	// ==================================================
	// Grouped signals
	// ==================================================
	typedef struct packed {
		logic eeprom;                // Bus access hits EEPROM
		logic sram;                  // Bus access hits SRAM
		logic flash;                 // Bus access hits Flash
	} save_kind_t;

	typedef struct packed {
		logic        mounted;        // One-cycle mount strobe from the host
		logic        readonly;
		logic [31:0] size;           // Image size in bytes
	} image_info_t;

	typedef struct packed {
		logic      req;              // One-cycle request pulse
		logic      rnw;              // 1 read from memory (save), 0 write (load)
		mem_addr_t addr;
		buf_word_t wdata;
	} mem_cmd_t;

	typedef struct packed {
		logic    rd;                 // Read sector from SD into the buffer
		logic    wr;                 // Write the buffer out to SD
		sector_t lba;
	} sd_cmd_t;

	// Transfer sequencer states
	typedef enum logic [2:0] {IDLE, LD_WAIT_SD, LD_COPY, SV_COPY, SV_WAIT_SD} bk_state_e;

endpackage

/* bk_sector_buffer.sv */
// Both ports share clk_sys, a same-address write on both ports in one cycle is undefined
`timescale 1ns/1ps
`include "bk_defines.svh"

module bk_sector_buffer (
	input  logic              clk_sys,
	// Port A, memory side
	input  bk_pkg::word_idx_t a_addr,
	input  logic              a_we,
	input  bk_pkg::buf_word_t a_wdata,
	output bk_pkg::buf_word_t a_rdata,
	// Port B, SD host side
	input  bk_pkg::word_idx_t b_addr,
	input  logic              b_we,
	input  bk_pkg::buf_word_t b_wdata,
	output bk_pkg::buf_word_t b_rdata
);

	// ==================================================
	// Storage, one sector of words
	// ==================================================
	bk_pkg::buf_word_t mem [`BK_WORDS];

	always_ff @(posedge clk_sys) begin
		if (a_we)
			mem[a_addr] <= a_wdata;                  // Memory read data on save
		if (b_we)
			mem[b_addr] <= b_wdata;                  // SD sector data on load
		a_rdata <= mem[a_addr];                      // Registered, one cycle after address
		b_rdata <= mem[b_addr];
	end

endmodule

/* bk_save_size.sv */
// A mounted image fixes the size until the next cart_start, sizes above 128 KiB are not seen
`timescale 1ns/1ps
`include "bk_defines.svh"

module bk_save_size (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                cart_start,     // New cartridge, forget the old size
	input  bk_pkg::save_kind_t  save_kind,
	input  logic                bus_req,        // Strobe of one save bus access
	input  logic                flash_1m,
	input  bk_pkg::image_info_t image,
	input  logic                busy,           // Transfer running
	output bk_pkg::sector_t     save_sz,
	output logic                bk_ena,
	output logic                pending
);

	logic            use_img;                  // Size locked by a mounted image
	logic            save_hit;
	logic            img_ok;
	bk_pkg::sector_t kind_mask;

	// ==================================================
	// Size tracking
	// ==================================================
	assign save_hit  = bus_req & (|save_kind);
	assign img_ok    = image.mounted & (|image.size) & ~image.readonly;
	assign kind_mask = (save_kind.eeprom ? `BK_EEPROM_MASK : 8'h00)
		| (save_kind.sram ? `BK_SRAM_MASK : 8'h00)
		| (save_kind.flash ? ({flash_1m, 7'h00} | `BK_FLASH_MASK) : 8'h00);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			save_sz <= '0;
			use_img <= 1'b0;
		end else begin
			if (cart_start) begin
				save_sz <= '0;
				use_img <= 1'b0;
			end
			if (bus_req && !use_img)
				save_sz <= save_sz | kind_mask;      // Grows with each kind touched
			if (img_ok) begin
				use_img <= 1'b1;
				save_sz <= image.size[16:9] - 1'b1;  // Bytes to last sector index
			end
		end
	end

	assign bk_ena = |save_sz;                      // Nothing to move at size zero

	// ==================================================
	// Unsaved data flag
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset)
			pending <= 1'b0;
		else if (save_hit)
			pending <= 1'b1;                         // New write wins over a running save
		else if (busy)
			pending <= 1'b0;
	end

endmodule

/* bk_word_mover.sv */
// One memory request in flight at a time, lba must hold steady while mover_start is high
`timescale 1ns/1ps
`include "bk_defines.svh"

module bk_word_mover (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              mover_start,    // Level, held for the whole sector
	input  logic              loading,        // 1 buffer to memory, 0 memory to buffer
	input  logic              mem_ready,
	input  bk_pkg::sector_t   lba,
	output bk_pkg::mem_cmd_t  mem_cmd,
	output bk_pkg::word_idx_t word_idx,
	output logic              buf_we,         // Port A write of returned read data
	output logic              mover_done      // Held until mover_start drops
);

	logic req_q;
	logic in_flight;                          // Request issued, waiting for mem_ready

	// ==================================================
	// Word walk
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset || !mover_start) begin
			word_idx   <= '0;                        // Rearm for the next sector
			req_q      <= 1'b0;
			in_flight  <= 1'b0;
			mover_done <= 1'b0;
		end else begin
			req_q <= 1'b0;                           // Pulse only
			if (!mover_done) begin
				if (!in_flight) begin
					req_q     <= 1'b1;                   // Address settled a cycle ago
					in_flight <= 1'b1;
				end else if (mem_ready) begin
					in_flight <= 1'b0;
					if (word_idx != bk_pkg::word_idx_t'(`BK_WORDS - 1))
						word_idx <= word_idx + 1'b1;
					else
						mover_done <= 1'b1;              // Last word of the sector
				end
			end
		end
	end

	// Save reads land in the buffer at the current word
	assign buf_we = ~loading & mem_ready & in_flight;

	// Write data is filled in at the top from buffer port A
	assign mem_cmd = '{
		req:   req_q,
		rnw:   ~loading,
		addr:  {lba, word_idx},
		wdata: '0
	};

	// Memory never answers without a request outstanding
	a_ready_in_flight: assert property (@(posedge clk_sys) disable iff (reset)
		mem_ready |-> in_flight);

endmodule

/* bk_transfer_fsm.sv */
// Triggers are sampled on clk_sys only, a load always walks all 256 sectors whatever the save size
`timescale 1ns/1ps
`include "bk_defines.svh"

module bk_transfer_fsm (
	input  logic             clk_sys,
	input  logic             reset,
	input  logic             load_req,       // Menu load request, edge triggered
	input  logic             save_req,       // Menu save request, edge triggered
	input  logic             autosave_en,
	input  logic             osd_status,     // High while the menu is open
	input  logic             cart_loading,
	input  logic             image_mounted,
	input  logic             bk_ena,         // Non-zero save size known
	input  logic             pending,        // Unsaved writes present
	input  bk_pkg::sector_t  save_sz,        // Last sector of a save
	input  logic             sd_ack,
	input  logic             mover_done,
	output bk_pkg::sd_cmd_t  sd_cmd,
	output logic             loading,
	output logic             mover_start,
	output logic             busy
);

	bk_pkg::bk_state_e state;

	logic old_load, old_save, old_auto, old_ack;
	logic mount_d;                            // Mount seen during cart load, one cycle late
	logic autosave;
	logic ack_rise, ack_fall;
	logic want_load, trigger;

	// ==================================================
	// Edge detection
	// ==================================================
	assign autosave  = osd_status & autosave_en;      // Menu opened with autosave on
	assign ack_rise  = ~old_ack & sd_ack;              // Host took the command
	assign ack_fall  = old_ack & ~sd_ack;              // Sector finished
	assign want_load = load_req | mount_d;
	assign trigger   = bk_ena & ((~old_load & load_req) | (~old_save & save_req)
		| (~old_auto & autosave & pending) | mount_d);
	assign busy      = (state != bk_pkg::IDLE);

	// The delay on the mount lets the new save size reach bk_ena first
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_load <= 1'b0;
			old_save <= 1'b0;
			old_auto <= 1'b0;
			old_ack  <= 1'b0;
			mount_d  <= 1'b0;
		end else begin
			old_load <= load_req;
			old_save <= save_req;
			old_auto <= autosave;
			old_ack  <= sd_ack;
			mount_d  <= cart_loading & image_mounted;
		end
	end

	// ==================================================
	// Sector sequencer
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state       <= bk_pkg::IDLE;
			sd_cmd      <= '0;
			loading     <= 1'b0;
			mover_start <= 1'b0;
		end else begin
			if (ack_rise) begin
				sd_cmd.rd <= 1'b0;                     // Strobes drop once acknowledged
				sd_cmd.wr <= 1'b0;
			end
			case (state)
				bk_pkg::IDLE: begin
					sd_cmd.lba  <= '0;
					mover_start <= 1'b0;
					loading     <= 1'b0;
					if (trigger) begin
						loading <= want_load;
						if (want_load) begin
							sd_cmd.rd <= 1'b1;             // Load starts with an SD read
							state     <= bk_pkg::LD_WAIT_SD;
						end else begin
							mover_start <= 1'b1;           // Save starts with a memory copy
							state       <= bk_pkg::SV_COPY;
						end
					end
				end
				bk_pkg::LD_WAIT_SD: if (ack_fall) begin
					mover_start <= 1'b1;                   // Buffer full, push to memory
					state       <= bk_pkg::LD_COPY;
				end
				bk_pkg::LD_COPY: if (mover_done) begin
					mover_start <= 1'b0;
					sd_cmd.lba  <= sd_cmd.lba + 1'b1;
					if (sd_cmd.lba == bk_pkg::sector_t'(`BK_LOAD_SECTORS - 1)) begin
						state <= bk_pkg::IDLE;             // Last sector done
					end else begin
						sd_cmd.rd <= 1'b1;
						state     <= bk_pkg::LD_WAIT_SD;
					end
				end
				bk_pkg::SV_COPY: if (mover_done) begin
					mover_start <= 1'b0;
					sd_cmd.wr   <= 1'b1;                   // Buffer holds the sector now
					state       <= bk_pkg::SV_WAIT_SD;
				end
				bk_pkg::SV_WAIT_SD: if (ack_fall) begin
					sd_cmd.lba <= sd_cmd.lba + 1'b1;
					if (sd_cmd.lba == save_sz) begin
						state <= bk_pkg::IDLE;
					end else begin
						mover_start <= 1'b1;
						state       <= bk_pkg::SV_COPY;
					end
				end
				default: state <= bk_pkg::IDLE;
			endcase
		end
	end

	// Host sees at most one sector command at a time
	a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_cmd.rd && sd_cmd.wr));

endmodule

/* backup_ram_ctrl.sv */
// Single clk_sys domain, memory and SD sides use plain strobes with no extra handshake
`timescale 1ns/1ps

module backup_ram_ctrl (
	input  logic                clk_sys,
	input  logic                reset,
	// Triggers
	input  logic                load_req,
	input  logic                save_req,
	input  logic                autosave_en,
	input  logic                osd_status,
	input  logic                cart_loading,
	input  logic                cart_start,
	// Save activity and image
	input  bk_pkg::save_kind_t  save_kind,
	input  logic                bus_req,
	input  logic                flash_1m,
	input  bk_pkg::image_info_t image,
	// Memory channel
	input  logic                mem_ready,
	input  bk_pkg::buf_word_t   mem_rdata,
	output bk_pkg::mem_cmd_t    mem_cmd,
	// SD host
	input  logic                sd_ack,
	input  bk_pkg::word_idx_t   sd_buff_addr,
	input  logic                sd_buff_wr,
	input  bk_pkg::buf_word_t   sd_buff_dout,
	output bk_pkg::sd_cmd_t     sd_cmd,
	output bk_pkg::buf_word_t   sd_buff_din,
	// Status
	output logic                busy,
	output logic                pending
);

	logic              loading;
	logic              mover_start;
	logic              mover_done;
	logic              buf_we;
	logic              bk_ena;
	bk_pkg::sector_t   save_sz;
	bk_pkg::word_idx_t word_idx;
	bk_pkg::buf_word_t a_rdata;                // Buffer word headed for memory
	bk_pkg::mem_cmd_t  mover_cmd;

	// ==================================================
	// Control
	// ==================================================
	bk_transfer_fsm u_fsm (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.load_req      (load_req),
		.save_req      (save_req),
		.autosave_en   (autosave_en),
		.osd_status    (osd_status),
		.cart_loading  (cart_loading),
		.image_mounted (image.mounted),
		.bk_ena        (bk_ena),
		.pending       (pending),
		.save_sz       (save_sz),
		.sd_ack        (sd_ack),
		.mover_done    (mover_done),
		.sd_cmd        (sd_cmd),
		.loading       (loading),
		.mover_start   (mover_start),
		.busy          (busy)
	);

	bk_word_mover u_mover (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.mover_start (mover_start),
		.loading     (loading),
		.mem_ready   (mem_ready),
		.lba         (sd_cmd.lba),              // Sector being moved
		.mem_cmd     (mover_cmd),
		.word_idx    (word_idx),
		.buf_we      (buf_we),
		.mover_done  (mover_done)
	);

	// ==================================================
	// Data
	// ==================================================
	bk_sector_buffer u_buffer (
		.clk_sys (clk_sys),
		.a_addr  (word_idx),
		.a_we    (buf_we),
		.a_wdata (mem_rdata),
		.a_rdata (a_rdata),
		.b_addr  (sd_buff_addr),
		.b_we    (sd_buff_wr),
		.b_wdata (sd_buff_dout),
		.b_rdata (sd_buff_din)
	);

	bk_save_size u_save_size (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cart_start (cart_start),
		.save_kind  (save_kind),
		.bus_req    (bus_req),
		.flash_1m   (flash_1m),
		.image      (image),
		.busy       (busy),
		.save_sz    (save_sz),
		.bk_ena     (bk_ena),
		.pending    (pending)
	);

	// Load writes carry the buffer word addressed by the mover
	assign mem_cmd = '{
		req:   mover_cmd.req,
		rnw:   mover_cmd.rnw,
		addr:  mover_cmd.addr,
		wdata: a_rdata
	};

endmodule

/* tb_clock_gen.sv */
// Clock runs from time zero and reset drops 1 ns after the last reset edge, so stimulus stays aligned
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 20,        // 50 MHz clk_sys
	parameter int RESET_CYCLES = 16
) (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD_NS / 2) clk_sys = ~clk_sys;
	end

	// Synchronous reset held over the first rising edges
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#1 reset = 1'b0;                         // Same offset as all other stimulus
	end

endmodule

/* tb_backup_ram.sv */
// Memory answers in 1 to 4 cycles, the SD host moves one whole sector per ack, the run takes ~1.5M cycles
`timescale 1ns/1ps
`include "bk_defines.svh"

module tb_backup_ram;

	localparam int SECTOR_CYCLES  = 2000;                 // Worst case 6 cycles a word plus SD
	localparam int TOTAL_SECTORS  = 912;                  // Sum of all transfers below
	localparam int TIMEOUT_CYCLES = TOTAL_SECTORS * SECTOR_CYCLES + 20000;
	localparam logic [15:0] SD_OFFSET = 16'h3C5A;         // Added to every word the host loads

	logic clk_sys, reset;
	logic load_req, save_req, autosave_en, osd_status, cart_loading, cart_start;
	logic bus_req, flash_1m, mem_ready, sd_ack, sd_buff_wr, busy, pending;
	bk_pkg::save_kind_t  save_kind;
	bk_pkg::image_info_t image;
	bk_pkg::buf_word_t   mem_rdata, sd_buff_dout, sd_buff_din;
	bk_pkg::word_idx_t   sd_buff_addr;
	bk_pkg::mem_cmd_t    mem_cmd;
	bk_pkg::sd_cmd_t     sd_cmd;

	bk_pkg::buf_word_t mem_model [`BK_LOAD_SECTORS * `BK_WORDS];  // Emulator memory, {sector, word}
	integer seed = 36;
	int cycle_count = 0;
	int checks = 0, errors = 0, test_errs = 0;
	int sd_rd_count, sd_wr_count, mem_wr_count, words_checked;

	tb_clock_gen u_clock_gen (.clk_sys(clk_sys), .reset(reset));

	backup_ram_ctrl u_backup_ram_ctrl (.*);

	// ==================================================
	// Helpers
	// ==================================================
	function automatic bk_pkg::buf_word_t sd_word(input int s, input int w);
		return bk_pkg::buf_word_t'(s * `BK_WORDS + w) + SD_OFFSET;  // Host pattern on load
	endfunction

	task automatic check(input bit ok, input string msg);
		checks++;
		assert (ok) else begin
			$display("FAILED at %0t: %s", $time, msg);
			errors++;
		end
	endtask

	task automatic next_slot();
		@(posedge clk_sys);
		#1;                                      // Outputs settled, inputs set for next edge
	endtask

	task automatic wait_busy(input logic level, input int limit);
		int n;
		n = 0;
		while (busy !== level && n < limit) begin
			next_slot();
			n++;
		end
		if (busy !== level) begin
			$display("Transfer stuck: busy did not go to %0b within %0d cycles", level, limit);
			errors++;
		end
	endtask

	task automatic transfer(input int sectors);
		wait_busy(1'b1, 10);
		load_req = 1'b0;                         // Requests are edge triggered
		save_req = 1'b0;
		wait_busy(1'b0, sectors * SECTOR_CYCLES);
	endtask

	task automatic save_activity(input bk_pkg::save_kind_t kind, input logic f1m);
		save_kind = kind;
		flash_1m  = f1m;
		bus_req   = 1'b1;                        // One bus access to save hardware
		next_slot();
		bus_req   = 1'b0;
		save_kind = '0;
	endtask

	task automatic clear_counts();
		sd_rd_count   = 0;
		sd_wr_count   = 0;
		mem_wr_count  = 0;
		words_checked = 0;
	endtask

	task automatic report(input string name);
		$display("%s: %s", name, (errors == test_errs) ? "PASS" : "FAIL");
		test_errs = errors;
	endtask

	// ==================================================
	// Memory model
	// ==================================================
	initial begin : memory_model
		bk_pkg::mem_cmd_t hold;
		int               wait_left;
		mem_ready = 1'b0;
		mem_rdata = '0;
		hold      = '0;
		wait_left = 0;
		forever begin
			next_slot();
			mem_ready = 1'b0;
			if (wait_left > 0) begin
				check(!mem_cmd.req && mem_cmd.addr == hold.addr
					&& (hold.rnw || mem_cmd.wdata == hold.wdata), "request changed in flight");
				wait_left--;
				if (wait_left == 0) begin
					mem_ready = 1'b1;
					if (hold.rnw) begin
						mem_rdata = mem_model[hold.addr];       // Save reads
					end else begin
						check(hold.wdata == sd_word(hold.addr[15:8], hold.addr[7:0]),
							$sformatf("memory write at %h carries %h", hold.addr, hold.wdata));
						mem_model[hold.addr] = hold.wdata;
						mem_wr_count++;
					end
				end
			end else if (mem_cmd.req) begin
				hold      = mem_cmd;
				wait_left = 1 + ($random(seed) & 3);        // 1 to 4 cycles
			end
		end
	end

	// ==================================================
	// SD host model
	// ==================================================
	initial begin : sd_host
		bk_pkg::sector_t lba;
		logic            is_rd;
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_wr   = 1'b0;
		sd_buff_dout = '0;
		forever begin
			next_slot();
			if (sd_cmd.rd || sd_cmd.wr) begin
				lba   = sd_cmd.lba;
				is_rd = sd_cmd.rd;
				check(lba == bk_pkg::sector_t'(is_rd ? sd_rd_count : sd_wr_count),
					$sformatf("SD command for sector %0d out of order", lba));
				if (is_rd)
					sd_rd_count++;
				else
					sd_wr_count++;
				sd_ack = 1'b1;
				for (int w = 0; w < `BK_WORDS; w++) begin
					sd_buff_addr = bk_pkg::word_idx_t'(w);
					sd_buff_wr   = is_rd;                  // Load fills the buffer
					sd_buff_dout = sd_word(lba, w);
					next_slot();
					if (w == 0)
						check(!sd_cmd.rd && !sd_cmd.wr, "SD command held after ack");
					if (!is_rd) begin
						check(sd_buff_din == mem_model[{lba, bk_pkg::word_idx_t'(w)}],
							$sformatf("SD read %h at sector %0d word %0d", sd_buff_din, lba, w));
						words_checked++;
					end
				end
				sd_buff_wr = 1'b0;
				sd_ack     = 1'b0;                       // Falling ack ends the sector
			end
		end
	end

	// Hard stop in case a transfer never ends
	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Some tests failed");
			$finish;
		end
	end

	// ==================================================
	// Stimulus
	// ==================================================
	initial begin : stimulus
		load_req     = 1'b0;
		save_req     = 1'b0;
		autosave_en  = 1'b0;
		osd_status   = 1'b0;
		cart_loading = 1'b0;
		cart_start   = 1'b0;
		save_kind    = '0;
		bus_req      = 1'b0;
		flash_1m     = 1'b0;
		image        = '0;
		clear_counts();
		for (int i = 0; i < $size(mem_model); i++)
			mem_model[i] = bk_pkg::buf_word_t'($random(seed));
		wait (reset === 1'b0);
		next_slot();

		check(sd_cmd == '0 && !mem_cmd.req && !busy && !pending, "outputs not idle after reset");
		load_req = 1'b1;
		repeat (20) begin
			next_slot();
			check(!busy, "load started with save size zero");
		end
		load_req = 1'b0;
		report("Test 1 idle after reset, no load at size zero");

		save_activity('{eeprom: 1'b0, sram: 1'b1, flash: 1'b0}, 1'b0);
		check(pending, "pending not set by SRAM write");
		save_req = 1'b1;
		wait_busy(1'b1, 10);
		save_req = 1'b0;
		next_slot();
		check(!pending, "pending not cleared by save");
		wait_busy(1'b0, 64 * SECTOR_CYCLES);
		check(sd_wr_count == 64 && sd_rd_count == 0,
			$sformatf("SRAM save wrote %0d sectors, expected 64", sd_wr_count));
		report("Test 2 SRAM save of 64 sectors");
		check(words_checked == 64 * `BK_WORDS, "SD host did not read every saved word");
		report("Test 3 saved words match memory");

		clear_counts();
		load_req = 1'b1;
		transfer(256);
		check(sd_rd_count == 256 && mem_wr_count == 256 * `BK_WORDS,
			$sformatf("load read %0d sectors, wrote %0d words", sd_rd_count, mem_wr_count));
		report("Test 4 load of 256 sectors");

		autosave_en = 1'b1;
		osd_status  = 1'b1;                      // Menu opens with nothing pending
		repeat (10) begin
			next_slot();
			check(!busy, "autosave started without pending data");
		end
		save_activity('{eeprom: 1'b1, sram: 1'b0, flash: 1'b0}, 1'b0);
		repeat (10) begin
			next_slot();
			check(!busy, "autosave started without a menu edge");
		end
		osd_status = 1'b0;
		next_slot();
		next_slot();
		clear_counts();
		osd_status = 1'b1;                       // Fresh edge with pending set
		transfer(64);
		check(sd_wr_count == 64, $sformatf("autosave wrote %0d sectors", sd_wr_count));
		osd_status  = 1'b0;
		autosave_en = 1'b0;
		report("Test 5 autosave on menu edge");

		cart_loading = 1'b1;
		cart_start   = 1'b1;
		next_slot();
		cart_start = 1'b0;
		clear_counts();
		image = '{mounted: 1'b1, readonly: 1'b0, size: 32'd8192};  // 8 KiB image
		next_slot();
		image.mounted = 1'b0;
		transfer(256);
		cart_loading = 1'b0;
		check(sd_rd_count == 256, $sformatf("mount load read %0d sectors", sd_rd_count));
		save_activity('{eeprom: 1'b0, sram: 1'b1, flash: 1'b0}, 1'b0);  // Size stays locked
		clear_counts();
		save_req = 1'b1;
		transfer(16);
		check(sd_wr_count == 16, $sformatf("image save wrote %0d sectors", sd_wr_count));
		cart_start = 1'b1;                       // New cartridge drops the image size
		next_slot();
		cart_start = 1'b0;
		save_activity('{eeprom: 1'b0, sram: 1'b0, flash: 1'b1}, 1'b1);
		clear_counts();
		save_req = 1'b1;
		transfer(256);
		check(sd_wr_count == 256, $sformatf("1M Flash save wrote %0d sectors", sd_wr_count));
		report("Test 6 image mount and Flash sizes");

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* tb.f */
+incdir+.
bk_pkg.sv
bk_sector_buffer.sv
bk_save_size.sv
bk_word_mover.sv
bk_transfer_fsm.sv
backup_ram_ctrl.sv
tb_clock_gen.sv
tb_backup_ram.sv

/* run_sim.sh */
#!/bin/sh
# Build the backup RAM testbench with Verilator and judge the run from its log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_backup_ram -f tb.f

./obj_dir/Vtb_backup_ram 2>&1 | tee sim.log

if grep -q "All tests passed" sim.log; then
	echo "Simulation PASS"
else
	echo "Simulation FAIL"
	exit 1
fi
